// File: Makefile
# Verilator flow for the voice recorder menu controller

VERILATOR ?= verilator
TOP       ?= voice_recorder_tb
SRC_LIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -Wno-fatal

# Assertions drive the checking, so --assert is always on
COMMON = --timing --assert -f $(SRC_LIST) --top-module $(TOP)

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(COMMON) $(VFLAGS)

build:
	$(VERILATOR) --binary $(COMMON) $(VFLAGS) -Mdir $(OBJ_DIR)

# Pass only when the run prints the pass message
sim: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+common
common/recorder_pkg.sv
keypad/keypad_debounce.sv
keypad/key_decoder.sv
src/track_table.sv
src/menu_fsm.sv
src/voice_recorder_top.sv
sim/tb_clock_gen.sv
sim/voice_recorder_props.sv
sim/voice_recorder_tb.sv

// File: common/recorder_cfg.svh
`ifndef RECORDER_CFG_SVH
`define RECORDER_CFG_SVH

////////////////////////////////////////////////////////////
// Memory layout
////////////////////////////////////////////////////////////

// Record address width, sized for the full RAM
`define REC_ADDR_W 26

// Number of message slots
`define REC_TRACKS 5

// Words per region, kept small for simulation
// Full-size build uses 'h333333
`define REC_TRACK_WORDS 64

// Volume setting width
`define REC_VOL_W 3

////////////////////////////////////////////////////////////
// Keypad timing
////////////////////////////////////////////////////////////

// System cycles per debounce tick
`define KEY_TICK_DIV 4

// Ticks a line must hold a new level before it is accepted
`define KEY_STABLE_TICKS 3

`endif

// File: common/recorder_pkg.sv
`default_nettype none

`include "recorder_cfg.svh"

package recorder_pkg;

	// Decoded keypad key
	typedef enum logic [3:0] {
		KEY_NONE = 4'd0,
		KEY_0    = 4'd1,
		KEY_1    = 4'd2,
		KEY_2    = 4'd3,
		KEY_3    = 4'd4,
		KEY_4    = 4'd5,
		KEY_5    = 4'd6,
		KEY_6    = 4'd7,
		KEY_A    = 4'd8,
		KEY_B    = 4'd9
	} kp_key_t;

	// Raw or debounced keypad lines, active high
	typedef struct packed {
		logic [3:0] rows;
		logic [3:0] cols;
	} kp_lines_t;

	// One-cycle key press event
	typedef struct packed {
		logic    valid;
		kp_key_t key;
	} key_evt_t;

	// Menu states
	typedef enum logic [3:0] {
		ST_INIT      = 4'd0,
		ST_MENU      = 4'd1,
		ST_PLAY_MENU = 4'd2,
		ST_PLAY      = 4'd3,
		ST_REC_INIT  = 4'd4,
		ST_DEL_MENU  = 4'd5,
		ST_DEL       = 4'd6,
		ST_DEL_ALL   = 4'd7,
		ST_MEM_FULL  = 4'd8,
		ST_VOLUME    = 4'd9,
		ST_VOL_UP    = 4'd10,
		ST_VOL_DOWN  = 4'd11,
		ST_RECORD    = 4'd12,
		ST_REC_END   = 4'd13
	} menu_state_t;

	// Slot index 0 to 4
	typedef logic [2:0] slot_t;

	// Track table operations
	typedef enum logic [2:0] {
		OP_NONE       = 3'd0,
		OP_ALLOC      = 3'd1,
		OP_CLOSE      = 3'd2,
		OP_DELETE     = 3'd3,
		OP_DELETE_ALL = 3'd4
	} track_op_t;

	typedef struct packed {
		track_op_t             op;
		slot_t                 slot;
		logic [`REC_ADDR_W-1:0] end_addr;
	} track_cmd_t;

	// Region and contents of the selected slot
	typedef struct packed {
		logic                  valid;
		logic [`REC_ADDR_W-1:0] base;
		logic [`REC_ADDR_W-1:0] limit;
		logic [`REC_ADDR_W-1:0] end_addr;
	} track_info_t;

	typedef struct packed {
		logic                  full;
		slot_t                 free_slot;
		logic [`REC_TRACKS-1:0] valid_mask;
	} track_status_t;

	// Playback request toward the audio path
	typedef struct packed {
		logic                  valid;
		slot_t                 slot;
		logic [`REC_ADDR_W-1:0] base;
		logic [`REC_ADDR_W-1:0] end_addr;
	} play_cmd_t;

endpackage

`default_nettype wire

// File: keypad/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
	input  wire logic                      pb_clk,
	input  wire logic                      pb_reset,
	input  wire recorder_pkg::kp_lines_t   lines,
	output recorder_pkg::key_evt_t         key_evt
);

	recorder_pkg::kp_key_t cur_key;
	recorder_pkg::kp_key_t prev_key;

	// True when exactly one bit is set
	function automatic logic is_onehot(input logic [3:0] v);
		return (v != 4'd0) && ((v & (v - 4'd1)) == 4'd0);
	endfunction

	// Row/column position to key code
	// Ghosted or partial patterns fall to KEY_NONE
	always_comb begin
		cur_key = recorder_pkg::KEY_NONE;
		if (is_onehot(lines.rows) && is_onehot(lines.cols)) begin
			case ({lines.rows, lines.cols})
				// Row 0
				8'b0001_0001: cur_key = recorder_pkg::KEY_1;
				8'b0001_0010: cur_key = recorder_pkg::KEY_2;
				8'b0001_0100: cur_key = recorder_pkg::KEY_3;
				8'b0001_1000: cur_key = recorder_pkg::KEY_A;
				// Row 1
				8'b0010_0001: cur_key = recorder_pkg::KEY_4;
				8'b0010_0010: cur_key = recorder_pkg::KEY_5;
				8'b0010_0100: cur_key = recorder_pkg::KEY_6;
				8'b0010_1000: cur_key = recorder_pkg::KEY_B;
				// Row 3, col 0
				8'b1000_0001: cur_key = recorder_pkg::KEY_0;
				default:      cur_key = recorder_pkg::KEY_NONE;
			endcase
		end
	end

	// Edge detect on the decoded key, one event per press
	always_ff @(posedge pb_clk or posedge pb_reset) begin
		if (pb_reset) begin
			prev_key <= recorder_pkg::KEY_NONE;
			key_evt  <= '0;
		end else begin
			prev_key      <= cur_key;
			key_evt.valid <= (cur_key != recorder_pkg::KEY_NONE) &&
			                 (prev_key == recorder_pkg::KEY_NONE);
			key_evt.key   <= cur_key;
		end
	end

endmodule

`default_nettype wire

// File: keypad/keypad_debounce.sv
`timescale 1ns/1ps
`default_nettype none

`include "recorder_cfg.svh"

module keypad_debounce (
	input  wire logic                      pb_clk,
	input  wire logic                      pb_reset,
	input  wire recorder_pkg::kp_lines_t   raw,
	output recorder_pkg::kp_lines_t        clean
);

	localparam int NLINES = $bits(recorder_pkg::kp_lines_t);
	localparam int TICK_W = (`KEY_TICK_DIV > 1) ? $clog2(`KEY_TICK_DIV) : 1;
	localparam int STAB_W = $clog2(`KEY_STABLE_TICKS + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic              tick;
	logic [NLINES-1:0] raw_bits;
	logic [NLINES-1:0] clean_q;
	logic [STAB_W-1:0] stab_cnt [NLINES];

	// Flatten rows and cols so each line is handled alike
	assign raw_bits = raw;
	assign clean    = clean_q;

	// Sample strobe once every KEY_TICK_DIV cycles
	assign tick = (tick_cnt == TICK_W'(`KEY_TICK_DIV - 1));

	always_ff @(posedge pb_clk or posedge pb_reset) begin
		if (pb_reset) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Per-line stability counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge pb_clk or posedge pb_reset) begin
		if (pb_reset) begin
			clean_q <= '0;
			for (int i = 0; i < NLINES; i++) begin
				stab_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NLINES; i++) begin
				// Input agrees with output, nothing pending
				if (raw_bits[i] == clean_q[i]) begin
					stab_cnt[i] <= '0;
				end else if (tick) begin
					// Last required tick at the new level
					if (stab_cnt[i] == STAB_W'(`KEY_STABLE_TICKS - 1)) begin
						clean_q[i]  <= raw_bits[i];
						stab_cnt[i] <= '0;
					end else begin
						stab_cnt[i] <= stab_cnt[i] + 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic pb_clk,
	output logic pb_reset
);

	localparam int PERIOD       = 4;
	localparam int RESET_CYCLES = 3;

	// Free-running clock
	initial begin
		pb_clk = 1'b0;
		forever #(PERIOD / 2) pb_clk = ~pb_clk;
	end

	// Reset spans three rising edges, drops on a falling edge
	initial begin
		pb_reset = 1'b1;
		#(RESET_CYCLES * PERIOD);
		pb_reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: sim/voice_recorder_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "recorder_cfg.svh"

module voice_recorder_props (
	input wire logic                        pb_clk,
	input wire logic                        pb_reset,
	input wire logic [`REC_VOL_W-1:0]       volume,
	input wire logic [`REC_ADDR_W-1:0]      rec_addr,
	input wire logic                        recording,
	input wire recorder_pkg::track_info_t   sel_info,
	input wire recorder_pkg::track_status_t status,
	input wire recorder_pkg::play_cmd_t     play_cmd
);

	localparam logic [`REC_VOL_W-1:0] VOL_MAX = {`REC_VOL_W{1'b1}};

	// Failed assertions so far
	int fail_count = 0;

	////////////////////////////////////////////////////////////
	// Volume register
	////////////////////////////////////////////////////////////

	// Saturation at both ends means no jump between 0 and max
	vol_no_wrap: assert property (@(posedge pb_clk) disable iff (pb_reset)
		!(($past(volume) == VOL_MAX) && (volume == '0)) &&
		!(($past(volume) == '0) && (volume == VOL_MAX)))
		else begin
			$error("volume wrapped around");
			fail_count++;
		end

	////////////////////////////////////////////////////////////
	// Record address and play request
	////////////////////////////////////////////////////////////

	// Address stays inside the region of the slot being recorded
	addr_in_region: assert property (@(posedge pb_clk) disable iff (pb_reset)
		recording |-> (rec_addr >= sel_info.base) && (rec_addr <= sel_info.limit))
		else begin
			$error("record address left its region");
			fail_count++;
		end

	// Play request is a single-cycle strobe
	play_one_cycle: assert property (@(posedge pb_clk) disable iff (pb_reset)
		play_cmd.valid |=> !play_cmd.valid)
		else begin
			$error("play strobe held longer than one cycle");
			fail_count++;
		end

	// Slot must be marked valid in the table mask
	play_valid_slot: assert property (@(posedge pb_clk) disable iff (pb_reset)
		play_cmd.valid |-> (play_cmd.slot < 3'd5) && status.valid_mask[play_cmd.slot])
		else begin
			$error("play request for an empty slot");
			fail_count++;
		end

endmodule

`default_nettype wire

// File: sim/voice_recorder_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "recorder_cfg.svh"

module voice_recorder_tb;

	localparam int WAIT_LIMIT = 400;
	localparam int WORDS      = `REC_TRACK_WORDS;
	localparam int VOL_MAX    = (1 << `REC_VOL_W) - 1;

	logic                      pb_clk;
	logic                      pb_reset;
	recorder_pkg::kp_lines_t   kypd_lines;
	logic                      sample_tick;
	recorder_pkg::menu_state_t state_code;
	logic [`REC_VOL_W-1:0]     volume;
	logic [`REC_ADDR_W-1:0]    rec_addr;
	logic                      recording;
	logic                      mem_full;
	logic [`REC_TRACKS-1:0]    track_valid;
	recorder_pkg::play_cmd_t   play_cmd;

	logic [31:0]               rng = 32'h2ce0;
	logic                      timed_out = 1'b0;
	int                        checks = 0;
	int                        errors = 0;
	int                        tests = 0;
	int                        failed_tests = 0;
	int                        plays = 0;
	recorder_pkg::play_cmd_t   last_play;

	tb_clock_gen u_clk (
		.pb_clk   (pb_clk),
		.pb_reset (pb_reset)
	);

	voice_recorder_top dut (
		.pb_clk      (pb_clk),
		.pb_reset    (pb_reset),
		.kypd_lines  (kypd_lines),
		.sample_tick (sample_tick),
		.state_code  (state_code),
		.volume      (volume),
		.rec_addr    (rec_addr),
		.recording   (recording),
		.mem_full    (mem_full),
		.track_valid (track_valid),
		.play_cmd    (play_cmd)
	);

	bind menu_fsm voice_recorder_props u_props (
		.pb_clk    (pb_clk),
		.pb_reset  (pb_reset),
		.volume    (volume),
		.rec_addr  (rec_addr),
		.recording (recording),
		.sel_info  (sel_info),
		.status    (status),
		.play_cmd  (play_cmd)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Keypad position as {row, col} with one line high in each group
	function automatic recorder_pkg::kp_lines_t key_lines(input recorder_pkg::kp_key_t k);
		logic [3:0] pos;
		pos = 4'h0;
		case (k)
			recorder_pkg::KEY_1: pos = {2'd0, 2'd0};
			recorder_pkg::KEY_2: pos = {2'd0, 2'd1};
			recorder_pkg::KEY_3: pos = {2'd0, 2'd2};
			recorder_pkg::KEY_A: pos = {2'd0, 2'd3};
			recorder_pkg::KEY_4: pos = {2'd1, 2'd0};
			recorder_pkg::KEY_5: pos = {2'd1, 2'd1};
			recorder_pkg::KEY_6: pos = {2'd1, 2'd2};
			recorder_pkg::KEY_B: pos = {2'd1, 2'd3};
			recorder_pkg::KEY_0: pos = {2'd3, 2'd0};
			default: return '0;
		endcase
		return {4'b0001 << pos[3:2], 4'b0001 << pos[1:0]};
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("mismatch at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int mark);
		tests++;
		if (errors == mark) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", name, errors - mark);
		end
	endtask

	// Hold 40 cycles and release 40 so debounce and decode settle
	task automatic press(input recorder_pkg::kp_key_t k);
		@(negedge pb_clk);
		kypd_lines = key_lines(k);
		repeat (40) @(negedge pb_clk);
		kypd_lines = '0;
		repeat (40) @(negedge pb_clk);
	endtask

	// One sample strobe after a pseudo-random gap of 0 to 3 cycles
	task automatic send_tick();
		rng = xorshift(rng);
		repeat (rng[1:0]) @(negedge pb_clk);
		sample_tick = 1'b1;
		@(negedge pb_clk);
		sample_tick = 1'b0;
	endtask

	task automatic wait_state(input recorder_pkg::menu_state_t s);
		int n;
		n = 0;
		while (state_code !== s && n < WAIT_LIMIT) begin
			@(negedge pb_clk);
			n++;
		end
		if (state_code !== s) begin
			$display("timeout at %0t ns: menu never reached %s", $time, s.name());
			timed_out = 1'b1;
			@(negedge pb_clk);
		end
	endtask

	task automatic wait_recording(input logic level);
		int n;
		n = 0;
		while (recording !== level && n < WAIT_LIMIT) begin
			@(negedge pb_clk);
			n++;
		end
		if (recording !== level) begin
			$display("timeout at %0t ns: recording flag never became %0d", $time, level);
			timed_out = 1'b1;
			@(negedge pb_clk);
		end
	endtask

	task automatic play_track(input recorder_pkg::kp_key_t k);
		press(recorder_pkg::KEY_1);
		wait_state(recorder_pkg::ST_PLAY_MENU);
		press(k);
		wait_state(recorder_pkg::ST_MENU);
	endtask

	// Capture play strobes mid-cycle
	always @(negedge pb_clk) begin
		if (!pb_reset && play_cmd.valid) begin
			plays++;
			last_play = play_cmd;
		end
	end

	initial begin
		wait (timed_out);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		int mark;
		int exp_vol;
		int n;
		logic [`REC_TRACKS-1:0] exp_mask;
		kypd_lines  = '0;
		sample_tick = 1'b0;

		mark = errors;
		wait_state(recorder_pkg::ST_MENU);
		check(volume, 0, "volume after reset");
		check(rec_addr, 0, "rec_addr after reset");
		check(recording, 0, "recording after reset");
		check(mem_full, 0, "mem_full after reset");
		check(track_valid, 0, "track_valid after reset");
		finish_test("reset", mark);

		////////////////////////////////////////////////////////////
		// Volume saturates at both ends
		////////////////////////////////////////////////////////////
		mark = errors;
		exp_vol = 0;
		press(recorder_pkg::KEY_5);
		wait_state(recorder_pkg::ST_VOLUME);
		repeat (9) begin
			press(recorder_pkg::KEY_A);
			exp_vol = (exp_vol < VOL_MAX) ? exp_vol + 1 : VOL_MAX;
			check(volume, exp_vol, "volume after up");
		end
		repeat (9) begin
			press(recorder_pkg::KEY_B);
			exp_vol = (exp_vol > 0) ? exp_vol - 1 : 0;
			check(volume, exp_vol, "volume after down");
		end
		press(recorder_pkg::KEY_0);
		wait_state(recorder_pkg::ST_MENU);
		finish_test("volume", mark);

		// Ten samples into slot 0 and a stop with key 0
		mark = errors;
		press(recorder_pkg::KEY_2);
		wait_recording(1'b1);
		check(rec_addr, 0, "record start address of slot 0");
		repeat (10) send_tick();
		check(rec_addr, 10, "address after ten samples");
		press(recorder_pkg::KEY_0);
		wait_recording(1'b0);
		wait_state(recorder_pkg::ST_MENU);
		check(track_valid, 5'b00001, "slot 0 valid");
		n = plays;
		play_track(recorder_pkg::KEY_1);
		check(plays, n + 1, "one play strobe for slot 0");
		check(last_play.slot, 0, "play slot");
		check(last_play.base, 0, "play base of slot 0");
		check(last_play.end_addr, 10, "play end of slot 0");
		finish_test("record_stop_key", mark);

		// Slot 1 runs until its region is full
		mark = errors;
		press(recorder_pkg::KEY_2);
		wait_recording(1'b1);
		check(rec_addr, WORDS, "record start address of slot 1");
		n = 0;
		while (recording && n < 2 * WORDS) begin
			send_tick();
			n++;
		end
		check(recording, 0, "recording stops at region end");
		check(rec_addr, 2 * WORDS - 1, "last address of slot 1");
		wait_state(recorder_pkg::ST_MENU);
		check(track_valid, 5'b00011, "slots 0 and 1 valid");
		n = plays;
		play_track(recorder_pkg::KEY_2);
		check(plays, n + 1, "one play strobe for slot 1");
		check(last_play.slot, 1, "play slot of slot 1");
		check(last_play.base, WORDS, "play base of slot 1");
		check(last_play.end_addr, 2 * WORDS - 1, "play end of slot 1");
		finish_test("record_to_limit", mark);

		////////////////////////////////////////////////////////////
		// Fill the table then delete one slot and all of them
		////////////////////////////////////////////////////////////
		mark = errors;
		repeat (3) begin
			press(recorder_pkg::KEY_2);
			wait_recording(1'b1);
			repeat (3) send_tick();
			press(recorder_pkg::KEY_0);
			wait_recording(1'b0);
			wait_state(recorder_pkg::ST_MENU);
		end
		exp_mask = '1;
		press(recorder_pkg::KEY_2);
		check(recording, 0, "no recording when memory is full");
		wait_state(recorder_pkg::ST_MENU);
		check(mem_full, 1, "mem_full with five slots");
		check(track_valid, exp_mask, "all slots valid");
		press(recorder_pkg::KEY_3);
		wait_state(recorder_pkg::ST_DEL_MENU);
		press(recorder_pkg::KEY_4);
		wait_state(recorder_pkg::ST_MENU);
		exp_mask[3] = 1'b0;
		check(track_valid, exp_mask, "slot 3 deleted");
		check(mem_full, 0, "mem_full after delete");
		press(recorder_pkg::KEY_4);
		wait_state(recorder_pkg::ST_MENU);
		exp_mask = '0;
		check(track_valid, exp_mask, "all slots deleted");
		n = plays;
		play_track(recorder_pkg::KEY_4);
		check(plays, n, "no play strobe for a deleted slot");
		finish_test("full_and_delete", mark);

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
		         tests, failed_tests, checks, errors, dut.u_menu.u_props.fail_count);
		if (errors == 0 && dut.u_menu.u_props.fail_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src/menu_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "recorder_cfg.svh"

module menu_fsm (
	input  wire logic                        pb_clk,
	input  wire logic                        pb_reset,
	input  wire recorder_pkg::key_evt_t      key_evt,
	input  wire logic                        sample_tick,
	input  wire recorder_pkg::track_info_t   sel_info,
	input  wire recorder_pkg::track_status_t status,
	output recorder_pkg::track_cmd_t         track_cmd,
	output recorder_pkg::slot_t              sel_slot,
	output recorder_pkg::menu_state_t        state,
	output logic [`REC_VOL_W-1:0]            volume,
	output logic [`REC_ADDR_W-1:0]           rec_addr,
	output logic                             recording,
	output recorder_pkg::play_cmd_t          play_cmd
);

	recorder_pkg::slot_t   slot_q;
	recorder_pkg::kp_key_t key;
	logic                  evt;
	logic                  stop_key;
	logic [`REC_ADDR_W-1:0] next_addr;
	logic                  at_limit;

	// Keys 1 to 5 pick a slot
	function automatic logic is_slot_key(input recorder_pkg::kp_key_t k);
		return (k >= recorder_pkg::KEY_1) && (k <= recorder_pkg::KEY_5);
	endfunction

	function automatic recorder_pkg::slot_t key_slot(input recorder_pkg::kp_key_t k);
		return recorder_pkg::slot_t'(k - recorder_pkg::KEY_1);
	endfunction

	assign evt       = key_evt.valid;
	assign key       = key_evt.key;
	assign stop_key  = evt && (key == recorder_pkg::KEY_0);
	assign next_addr = rec_addr + 1'b1;
	assign at_limit  = (next_addr >= sel_info.limit);
	assign recording = (state == recorder_pkg::ST_RECORD);

	// While allocating, look at the slot about to be taken
	assign sel_slot = (state == recorder_pkg::ST_REC_INIT) ? status.free_slot : slot_q;

	////////////////////////////////////////////////////////////
	// State register, address counter and volume
	////////////////////////////////////////////////////////////

	always_ff @(posedge pb_clk or posedge pb_reset) begin
		if (pb_reset) begin
			state    <= recorder_pkg::ST_INIT;
			slot_q   <= '0;
			volume   <= '0;
			rec_addr <= '0;
		end else begin
			case (state)
				recorder_pkg::ST_INIT: state <= recorder_pkg::ST_MENU;
				// Top-level menu selection
				recorder_pkg::ST_MENU: begin
					if (evt) begin
						case (key)
							recorder_pkg::KEY_1: state <= recorder_pkg::ST_PLAY_MENU;
							recorder_pkg::KEY_2: state <= recorder_pkg::ST_REC_INIT;
							recorder_pkg::KEY_3: state <= recorder_pkg::ST_DEL_MENU;
							recorder_pkg::KEY_4: state <= recorder_pkg::ST_DEL_ALL;
							recorder_pkg::KEY_5: state <= recorder_pkg::ST_VOLUME;
							default: begin
							end
						endcase
					end
				end
				// Slot pickers share one key map
				recorder_pkg::ST_PLAY_MENU, recorder_pkg::ST_DEL_MENU: begin
					if (evt && is_slot_key(key)) begin
						slot_q <= key_slot(key);
						state  <= (state == recorder_pkg::ST_PLAY_MENU) ?
						          recorder_pkg::ST_PLAY : recorder_pkg::ST_DEL;
					end else if (stop_key) begin
						state <= recorder_pkg::ST_MENU;
					end
				end
				// Find a free region or report full
				recorder_pkg::ST_REC_INIT: begin
					if (status.full) begin
						state <= recorder_pkg::ST_MEM_FULL;
					end else begin
						slot_q   <= status.free_slot;
						rec_addr <= sel_info.base;
						state    <= recorder_pkg::ST_RECORD;
					end
				end
				// One word per sample, stop on key 0 or end of region
				recorder_pkg::ST_RECORD: begin
					if (sample_tick) begin
						rec_addr <= next_addr;
					end
					if (stop_key || (sample_tick && at_limit)) begin
						state <= recorder_pkg::ST_REC_END;
					end
				end
				recorder_pkg::ST_VOLUME: begin
					if (evt && key == recorder_pkg::KEY_A) begin
						state <= recorder_pkg::ST_VOL_UP;
					end else if (evt && key == recorder_pkg::KEY_B) begin
						state <= recorder_pkg::ST_VOL_DOWN;
					end else if (stop_key) begin
						state <= recorder_pkg::ST_MENU;
					end
				end
				// Saturate at the top
				recorder_pkg::ST_VOL_UP: begin
					if (volume != '1) begin
						volume <= volume + 1'b1;
					end
					state <= recorder_pkg::ST_VOLUME;
				end
				// Saturate at zero
				recorder_pkg::ST_VOL_DOWN: begin
					if (volume != '0) begin
						volume <= volume - 1'b1;
					end
					state <= recorder_pkg::ST_VOLUME;
				end
				// Single-cycle actions all fall back to the menu
				default: state <= recorder_pkg::ST_MENU;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Track table commands and play request
	////////////////////////////////////////////////////////////

	always_comb begin
		track_cmd.op       = recorder_pkg::OP_NONE;
		track_cmd.slot     = slot_q;
		track_cmd.end_addr = rec_addr;
		case (state)
			recorder_pkg::ST_REC_INIT: begin
				if (!status.full) begin
					track_cmd.op   = recorder_pkg::OP_ALLOC;
					track_cmd.slot = status.free_slot;
				end
			end
			recorder_pkg::ST_REC_END: track_cmd.op = recorder_pkg::OP_CLOSE;
			recorder_pkg::ST_DEL:     track_cmd.op = recorder_pkg::OP_DELETE;
			recorder_pkg::ST_DEL_ALL: track_cmd.op = recorder_pkg::OP_DELETE_ALL;
			default: begin
			end
		endcase
	end

	// Empty slot passes through ST_PLAY silently
	always_comb begin
		play_cmd.valid    = (state == recorder_pkg::ST_PLAY) && sel_info.valid;
		play_cmd.slot     = slot_q;
		play_cmd.base     = sel_info.base;
		play_cmd.end_addr = sel_info.end_addr;
	end

endmodule

`default_nettype wire

// File: src/track_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "recorder_cfg.svh"

module track_table (
	input  wire logic                       pb_clk,
	input  wire logic                       pb_reset,
	input  wire recorder_pkg::track_cmd_t   cmd,
	input  wire recorder_pkg::slot_t        sel_slot,
	output recorder_pkg::track_info_t       sel_info,
	output recorder_pkg::track_status_t     status
);

	localparam int N  = `REC_TRACKS;
	localparam int AW = `REC_ADDR_W;

	logic [N-1:0]  valid_q;
	logic [AW-1:0] end_q [N];
	logic          cmd_ok;
	logic          sel_ok;
	logic [AW-1:0] sel_base;

	// Fixed region start for a slot
	function automatic logic [AW-1:0] slot_base(input recorder_pkg::slot_t s);
		return AW'(s) * AW'(`REC_TRACK_WORDS);
	endfunction

	// Slot indices 5 to 7 do not exist
	assign cmd_ok   = (cmd.slot < recorder_pkg::slot_t'(N));
	assign sel_ok   = (sel_slot < recorder_pkg::slot_t'(N));
	assign sel_base = slot_base(sel_slot);

	////////////////////////////////////////////////////////////
	// Command execution
	////////////////////////////////////////////////////////////

	// Valid bits
	always_ff @(posedge pb_clk or posedge pb_reset) begin
		if (pb_reset) begin
			valid_q <= '0;
		end else begin
			case (cmd.op)
				recorder_pkg::OP_ALLOC: begin
					if (cmd_ok) begin
						valid_q[cmd.slot] <= 1'b1;
					end
				end
				recorder_pkg::OP_DELETE: begin
					if (cmd_ok) begin
						valid_q[cmd.slot] <= 1'b0;
					end
				end
				recorder_pkg::OP_DELETE_ALL: begin
					valid_q <= '0;
				end
				default: begin
				end
			endcase
		end
	end

	// Stored end addresses, only meaningful while the slot is valid
	always_ff @(posedge pb_clk) begin
		if (cmd.op == recorder_pkg::OP_CLOSE && cmd_ok) begin
			end_q[cmd.slot] <= cmd.end_addr;
		end
	end

	////////////////////////////////////////////////////////////
	// Lookup and status
	////////////////////////////////////////////////////////////

	always_comb begin
		sel_info.valid    = sel_ok ? valid_q[sel_slot] : 1'b0;
		sel_info.base     = sel_base;
		// Last word of the region
		sel_info.limit    = sel_base + AW'(`REC_TRACK_WORDS - 1);
		sel_info.end_addr = sel_ok ? end_q[sel_slot] : '0;
	end

	always_comb begin
		status.full       = &valid_q;
		status.valid_mask = valid_q;
		// Scan downward so the lowest free slot wins
		status.free_slot  = '0;
		for (int k = N - 1; k >= 0; k--) begin
			if (!valid_q[k]) begin
				status.free_slot = recorder_pkg::slot_t'(k);
			end
		end
	end

endmodule

`default_nettype wire

// File: src/voice_recorder_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "recorder_cfg.svh"

module voice_recorder_top (
	input  wire logic                      pb_clk,
	input  wire logic                      pb_reset,
	input  wire recorder_pkg::kp_lines_t   kypd_lines,
	input  wire logic                      sample_tick,
	output recorder_pkg::menu_state_t      state_code,
	output logic [`REC_VOL_W-1:0]          volume,
	output logic [`REC_ADDR_W-1:0]         rec_addr,
	output logic                           recording,
	output logic                           mem_full,
	output logic [`REC_TRACKS-1:0]         track_valid,
	output recorder_pkg::play_cmd_t        play_cmd
);

	recorder_pkg::kp_lines_t     clean_lines;
	recorder_pkg::key_evt_t      key_evt;
	recorder_pkg::track_cmd_t    track_cmd;
	recorder_pkg::slot_t         sel_slot;
	recorder_pkg::track_info_t   sel_info;
	recorder_pkg::track_status_t status;

	// Status flags straight from the table
	assign mem_full    = status.full;
	assign track_valid = status.valid_mask;

	// Keypad front end
	keypad_debounce u_debounce (
		.pb_clk   (pb_clk),
		.pb_reset (pb_reset),
		.raw      (kypd_lines),
		.clean    (clean_lines)
	);

	key_decoder u_decoder (
		.pb_clk   (pb_clk),
		.pb_reset (pb_reset),
		.lines    (clean_lines),
		.key_evt  (key_evt)
	);

	// Menu control and slot bookkeeping
	menu_fsm u_menu (
		.pb_clk      (pb_clk),
		.pb_reset    (pb_reset),
		.key_evt     (key_evt),
		.sample_tick (sample_tick),
		.sel_info    (sel_info),
		.status      (status),
		.track_cmd   (track_cmd),
		.sel_slot    (sel_slot),
		.state       (state_code),
		.volume      (volume),
		.rec_addr    (rec_addr),
		.recording   (recording),
		.play_cmd    (play_cmd)
	);

	track_table u_tracks (
		.pb_clk   (pb_clk),
		.pb_reset (pb_reset),
		.cmd      (track_cmd),
		.sel_slot (sel_slot),
		.sel_info (sel_info),
		.status   (status)
	);

endmodule

`default_nettype wire
